//--- flist.f
verilog/fp_pkg.sv
verilog/find_first_1.sv
verilog/fp_align_add.sv
verilog/normalize.sv
verilog/fp_round_pack.sv
verilog/fp_add_top.sv
bench/fp_add_sva.sv
bench/fp_add_tb.sv

//--- Bender.yml
package:
  name: fp_add

sources:
  - files:
      - verilog/fp_pkg.sv
      - verilog/find_first_1.sv
      - verilog/fp_align_add.sv
      - verilog/normalize.sv
      - verilog/fp_round_pack.sv
      - verilog/fp_add_top.sv
  - target: simulation
    files:
      - bench/fp_add_sva.sv
      - bench/fp_add_tb.sv

//--- bench/fp_add_stimulus.txt
# Columns: operand a, operand b, sub bit, expected result (binary32 hex)
# Expected results use IEEE round to nearest, ties to even
3FC00000 3FC00000 0 40400000
3F800000 3F800000 0 40000000
40400000 3F800000 0 40800000
3FA00000 3FC00000 0 40300000
BFC00000 C0200000 0 C0800000
3F800000 3F000000 0 3FC00000
40000000 BF800000 1 40400000
3FC00000 3FC00000 1 00000000
C0200000 C0200000 1 00000000
3F800000 3F400000 1 3E800000
3F800001 3F800000 1 34000000
3F800000 3F7FFFFF 1 33800000
3F800003 3F800001 1 34800000
3F800000 3F800001 1 B4000000
3FC00000 BF800000 0 3F000000
00800001 00800000 1 00000001
00C00000 00800000 1 00400000
01000000 00C00000 1 00400000
00400000 00400000 0 00800000
00600000 00300000 0 00900000
00000001 00000002 0 00000003
00800000 00000001 1 007FFFFF
80000003 00000001 0 80000002
3F800000 33800000 0 3F800000
3F800001 33800000 0 3F800002
3F800000 33800001 0 3F800001
3F800000 33000000 0 3F800000
3F800000 33C00000 0 3F800001
3FFFFFFF 33800000 0 40000000
3F800001 3F800000 0 40000000
3F800003 3F800000 0 40000002
3F800000 33000000 1 3F800000
3F800000 00000001 0 3F800000
3F800000 00000001 1 3F800000
4B800000 3F800000 0 4B800000
4B800000 40400000 0 4B800002
7E800000 7E800000 0 7F000000
7F7FFFFF 7F7FFFFF 0 7F800000
7F7FFFFF 73000000 0 7F800000
FF7FFFFF FF7FFFFF 0 FF800000

//--- bench/fp_add_tb.sv
// Binary32 adder testbench
`timescale 1ns/100ps

module fp_add_tb
    import fp_pkg::*;
();

    localparam int    CLK_PERIOD    = 40;           // Clock period in ns
    localparam int    DRIVE_DELAY   = 5;            // Inputs change this long after the edge
    localparam int    RESET_CYCLES  = 8;
    localparam int    LATENCY       = 3;            // Request to result, in cycles
    localparam int    MAX_VECTORS   = 128;
    localparam int    DRAIN_TIMEOUT = 40;           // Cycles allowed for the last results
    localparam string STIM_FILE     = "bench/fp_add_stimulus.txt";

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    fp_word_t a;
    fp_word_t b;
    logic     sub;
    logic     out_valid;
    fp_word_t result;

    logic [31:0] vec_a   [MAX_VECTORS];             // Operand a of each vector
    logic [31:0] vec_b   [MAX_VECTORS];             // Operand b of each vector
    logic        vec_sub [MAX_VECTORS];             // Operation bit, set for a minus b
    logic [31:0] vec_res [MAX_VECTORS];             // Expected IEEE result
    int          num_vectors = 0;

    logic [31:0] expect_q [$];                      // Expected results in send order
    int          sent_q   [$];                      // Cycle in which each request was driven
    int          cycle_count = 0;
    logic [31:0] expected;
    int          sent_cycle;
    int          results_seen   = 0;
    int          value_errors   = 0;
    int          timing_errors  = 0;
    int          missing_errors = 0;
    int          file_errors    = 0;
    logic [7:0]  lfsr = 8'd96;                      // Gap generator state

    fp_add_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .sub       (sub),
        .out_valid (out_valid),
        .result    (result)
    );

    bind fp_add_top fp_add_sva u_sva (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .sum_valid  (sum_valid),
        .norm_valid (norm_valid),
        .out_valid  (out_valid),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;   // Reference for latency checks

    // Taps 8, 6, 5, 4 give a maximal length sequence
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        lfsr_next = {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);                // One step for each bit taken
            value = (value << 1) | lfsr[0];
        end
    endtask

    // Lines starting with # are column notes, blank lines are skipped
    task automatic load_stimulus();
        int          fd;
        int          code;
        string       line;
        logic [31:0] fa, fb, fs, fe;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            file_errors++;
            return;
        end
        while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() > 0 && line.getc(0) != "#") begin
                code = $sscanf(line, "%h %h %h %h", fa, fb, fs, fe);
                if (code == 4) begin
                    vec_a[num_vectors]   = fa;
                    vec_b[num_vectors]   = fb;
                    vec_sub[num_vectors] = fs[0];
                    vec_res[num_vectors] = fe;
                    num_vectors++;
                end
            end
        end
        $fclose(fd);
        if (num_vectors == 0) begin
            $display("Stimulus file holds no vectors");
            file_errors++;
        end
    endtask

    task automatic drive_op(input int idx);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b1;
        a        = vec_a[idx];
        b        = vec_b[idx];
        sub      = vec_sub[idx];
        expect_q.push_back(vec_res[idx]);           // Result must come back in this order
        sent_q.push_back(cycle_count);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        sub      = 1'b0;
    endtask

    // Outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (expect_q.size() == 0) begin
                $display("%0t: a result arrived with no request outstanding", $time);
                missing_errors++;
            end else begin
                expected   = expect_q.pop_front();
                sent_cycle = sent_q.pop_front();
                if (result !== expected) begin
                    $display("ERR %0t result got %h expected %h", $time, result, expected);
                    value_errors++;
                end
                if (cycle_count - sent_cycle != LATENCY) begin
                    $display("ERR %0t out_valid latency got %0d expected %0d", $time,
                             cycle_count - sent_cycle, LATENCY);
                    timing_errors++;
                end
                results_seen++;
            end
        end
    end

    initial begin
        int gap;
        int wait_cycles;
        int total;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        sub      = 1'b0;
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        for (int i = 0; i < num_vectors; i++) begin
            drive_op(i);
            draw_bits(1, gap);
            if (gap != 0) begin
                draw_bits(2, gap);                  // Idle run of zero to three cycles
                repeat (gap) drive_idle();
            end
        end
        drive_idle();
        wait_cycles = 0;
        while (results_seen < num_vectors && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (results_seen < num_vectors) begin
            $display("Results missing, %0d of %0d arrived before the timeout",
                     results_seen, num_vectors);
            missing_errors++;
        end
        repeat (2) @(posedge clk);                  // Let any late assertion fire
        total = value_errors + timing_errors + missing_errors + file_errors
              + UUT.u_sva.failures;
        $display("Errors: %0d value, %0d timing, %0d missing, %0d stimulus, %0d assertion",
                 value_errors, timing_errors, missing_errors, file_errors,
                 UUT.u_sva.failures);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- bench/fp_add_sva.sv
// Adder pipeline assertions
`timescale 1ns/100ps

module fp_add_sva
    import fp_pkg::*;
(
    input logic     clk,                            // Pipeline clock
    input logic     arst_n,                         // Asynchronous reset, active low
    input logic     in_valid,                       // Request strobe into stage 1
    input logic     sum_valid,                      // Stage 1 output strobe
    input logic     norm_valid,                     // Stage 2 output strobe
    input logic     out_valid,                      // Result strobe
    input fp_word_t result                          // Packed result word
);

    localparam int LATENCY = 3;                     // One register per stage

    int failures = 0;                               // Number of failed assertions

    // Every request returns exactly three cycles later
    a_req_to_result: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> ##LATENCY out_valid)
        else begin
            failures++;
            $error("out_valid missing three cycles after in_valid");
        end

    // And no result appears without a request three cycles earlier
    a_result_has_req: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(in_valid, LATENCY))
        else begin
            failures++;
            $error("out_valid without a matching in_valid");
        end

    // Strobes stay low while reset is applied
    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !sum_valid && !norm_valid && !out_valid)
        else begin
            failures++;
            $error("valid strobe high during reset");
        end

    // An all-ones exponent only ever encodes infinity here
    a_inf_encoding: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && result.exp == '1 |-> result.frac == '0)
        else begin
            failures++;
            $error("result with exponent 255 has a nonzero fraction");
        end

endmodule

//--- verilog/fp_add_top.sv
// Pipelined binary32 adder
`timescale 1ns/100ps

module fp_add_top
    import fp_pkg::*;
(
    input  logic     clk,                           // Pipeline clock
    input  logic     arst_n,                        // Asynchronous reset, active low
    input  logic     in_valid,                      // One-cycle request strobe
    input  fp_word_t a,                             // First operand
    input  fp_word_t b,                             // Second operand
    input  logic     sub,                           // Set for a minus b
    output logic     out_valid,                     // Result strobe, three cycles after in_valid
    output fp_word_t result                         // Rounded binary32 result
);

    logic  sum_valid;                               // Stage 1 to stage 2 strobe
    sum_t  sum;                                     // Aligned significand sum
    logic  norm_valid;                              // Stage 2 to stage 3 strobe
    norm_t norm;                                    // Normalized value before rounding

    // Stage 1, unpack, align and add
    fp_align_add u_align_add (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .sub       (sub),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    // Stage 2, shift the leading one to the hidden bit
    normalize u_normalize (
        .clk        (clk),
        .arst_n     (arst_n),
        .sum_valid  (sum_valid),
        .sum        (sum),
        .norm_valid (norm_valid),
        .norm       (norm)
    );

    // Stage 3, round to nearest even and pack
    fp_round_pack u_round_pack (
        .clk        (clk),
        .arst_n     (arst_n),
        .norm_valid (norm_valid),
        .norm       (norm),
        .out_valid  (out_valid),
        .result     (result)
    );

    // Each stage adds one register, so a request takes three cycles
    // and up to three operations are in flight at once

endmodule

//--- verilog/fp_round_pack.sv
// FP adder stage 3, round and pack
`timescale 1ns/100ps

module fp_round_pack
    import fp_pkg::*;
(
    input  logic     clk,                           // Pipeline clock
    input  logic     arst_n,                        // Asynchronous reset, active low
    input  logic     norm_valid,                    // Strobe from stage 2
    input  norm_t    norm,                          // Normalized significand and exponent
    output logic     out_valid,                     // Strobe for the packed result
    output fp_word_t result                         // Packed binary32 result
);

    logic                round_up;                  // Increment the kept significand
    logic [SIG_BITS+1:0] rounded;                   // Carry, hidden bit and fraction after rounding
    logic [EXP_BITS:0]   exp_r;                     // Exponent with room for overflow
    logic [SIG_BITS-1:0] frac_r;                    // Fraction after renormalization
    fp_word_t            res_d;                     // Next value of the result register

    // Nearest even, above half or exactly half with an odd kept LSB
    assign round_up = norm.sig[GUARD_POS] &
                      (norm.sig[ROUND_POS] | norm.sig[STKY_POS] | norm.sig[LSB_POS]);

    assign rounded = {1'b0, norm.sig[HID_POS:LSB_POS]} + (SIG_BITS+2)'(round_up);

    always_comb begin
        exp_r  = {1'b0, norm.exp};
        frac_r = rounded[SIG_BITS-1:0];
        if (rounded[SIG_BITS+1]) begin
            exp_r  = exp_r + 1'b1;                  // Rounding carried past the hidden bit
            frac_r = rounded[SIG_BITS:1];
        end else if (norm.exp == '0 && rounded[SIG_BITS]) begin
            exp_r = (EXP_BITS+1)'(1);               // Denormal rounded up into the normal range
        end

        res_d.sign = norm.sign;
        if (exp_r >= (EXP_BITS+1)'(EXP_MAX)) begin
            res_d.exp  = '1;                        // Saturate to infinity
            res_d.frac = '0;
        end else begin
            res_d.exp  = exp_r[EXP_BITS-1:0];
            res_d.frac = frac_r;
        end
    end

    // Output register, loads only on a valid normalized value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= norm_valid;
            if (norm_valid) begin
                result <= res_d;
            end
        end
    end

endmodule

//--- verilog/normalize.sv
// FP adder stage 2, normalization
`timescale 1ns/100ps

module normalize
    import fp_pkg::*;
(
    input  logic  clk,                              // Pipeline clock
    input  logic  arst_n,                           // Asynchronous reset, active low
    input  logic  sum_valid,                        // Strobe from stage 1
    input  sum_t  sum,                              // Raw sum from stage 1
    output logic  norm_valid,                       // Strobe for the registered result
    output norm_t norm                              // Normalized significand and exponent
);

    logic [4:0]           first_one;                // Index of the leading one in the sum
    logic [EXP_BITS-1:0]  norm_shift;               // Left shift distance after clamping
    logic [WORK_BITS-1:0] shifted;                  // Significand after the left shift
    norm_t                norm_d;                   // Next value of the norm register

    find_first_1 #(
        .WIDTH (WORK_BITS)
    ) u_ff1 (
        .vec (sum.sig),
        .pos (first_one)
    );

    always_comb begin
        norm_d.sign = sum.sign;
        norm_shift  = '0;
        shifted     = sum.sig;
        if (sum.carry) begin
            // Carry out, one step right and the dropped bit joins sticky
            norm_d.sig = {1'b1, sum.sig[WORK_BITS-1:2], sum.sig[1] | sum.sig[0]};
            norm_d.exp = sum.exp + 1'b1;
        end else if (sum.sig == '0) begin
            norm_d.sig = sum.sig;                   // Zero result
            norm_d.exp = '0;
        end else if (sum.exp == EXP_BITS'(1) && !sum.sig[HID_POS]) begin
            norm_d.sig = sum.sig;                   // Already at the bottom, stays denormal
            norm_d.exp = '0;
        end else begin
            // Move the leading one to the top as far as the exponent allows
            norm_shift = EXP_BITS'(WORK_BITS - 1) - EXP_BITS'(first_one);
            if (norm_shift >= sum.exp) begin
                norm_shift = sum.exp - 1'b1;        // Stop at exponent one
            end
            shifted    = sum.sig << norm_shift;
            norm_d.sig = shifted;
            // A clamped shift that leaves the top bit clear encodes as a denormal
            norm_d.exp = shifted[HID_POS] ? sum.exp - norm_shift : '0;
        end
    end

    // Output register, loads only on a valid sum
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            norm_valid <= 1'b0;
            norm       <= '0;
        end else begin
            norm_valid <= sum_valid;
            if (sum_valid) begin
                norm <= norm_d;
            end
        end
    end

endmodule

//--- verilog/fp_align_add.sv
// FP adder align and add stage
`timescale 1ns/100ps

module fp_align_add
    import fp_pkg::*;
(
    input  logic     clk,                           // Pipeline clock
    input  logic     arst_n,                        // Asynchronous reset, active low
    input  logic     in_valid,                      // One-cycle request strobe
    input  fp_word_t a,                             // First operand
    input  fp_word_t b,                             // Second operand
    input  logic     sub,                           // Set for a minus b
    output logic     sum_valid,                     // Strobe for the registered sum
    output sum_t     sum                            // Registered significand sum
);

    logic [EXP_BITS-1:0]  a_exp, b_exp;             // Effective exponents, denormals as 1
    logic [WORK_BITS-1:0] a_sig, b_sig;             // Significands with hidden bit and GRS room
    logic                 b_sign;                   // Sign of b after the operation bit
    logic                 a_big;                    // Operand a has the larger magnitude
    logic                 big_sign;
    logic [EXP_BITS-1:0]  big_exp, small_exp;
    logic [WORK_BITS-1:0] big_sig, small_sig;
    logic [EXP_BITS-1:0]  exp_diff;                 // Alignment shift distance
    logic [WORK_BITS-1:0] shifted;                  // Smaller significand after the shift
    logic [WORK_BITS-1:0] lost_mask;                // Bits that fall off the right end
    logic                 sticky;                   // OR of the lost bits
    logic [WORK_BITS-1:0] aligned;                  // Shifted significand with sticky folded in
    logic                 eff_sub;                  // Signs differ so magnitudes subtract
    logic [WORK_BITS:0]   raw;                      // Adder output including carry
    sum_t                 sum_d;                    // Next value of the sum register

    // A zero exponent has no hidden bit and reads as exponent one
    assign a_exp  = (a.exp == '0) ? EXP_BITS'(1) : a.exp;
    assign b_exp  = (b.exp == '0) ? EXP_BITS'(1) : b.exp;
    assign a_sig  = {a.exp != '0, a.frac, 3'b000};  // Hidden bit, fraction, empty GRS
    assign b_sig  = {b.exp != '0, b.frac, 3'b000};
    assign b_sign = b.sign ^ sub;                   // Subtraction is addition of a negated b

    // Exponent and fraction together order like the magnitude
    assign a_big = {a.exp, a.frac} >= {b.exp, b.frac};

    // Put the larger magnitude on the big side
    assign big_sign  = a_big ? a.sign : b_sign;
    assign big_exp   = a_big ? a_exp  : b_exp;
    assign small_exp = a_big ? b_exp  : a_exp;
    assign big_sig   = a_big ? a_sig  : b_sig;
    assign small_sig = a_big ? b_sig  : a_sig;
    assign exp_diff  = big_exp - small_exp;         // Never negative after the swap

    // Right shift of the smaller significand with sticky collection
    always_comb begin
        if (exp_diff >= EXP_BITS'(WORK_BITS)) begin
            shifted   = '0;                         // Everything shifts out
            lost_mask = '1;
        end else begin
            shifted   = small_sig >> exp_diff;
            lost_mask = ({{(WORK_BITS-1){1'b0}}, 1'b1} << exp_diff) - 1'b1;
        end
        sticky  = |(small_sig & lost_mask);
        aligned = {shifted[WORK_BITS-1:1], shifted[0] | sticky};
    end

    assign eff_sub = a.sign ^ b_sign;

    // The big side is never smaller so the subtraction never borrows
    always_comb begin
        if (eff_sub) begin
            raw = {1'b0, big_sig} - {1'b0, aligned};
        end else begin
            raw = {1'b0, big_sig} + {1'b0, aligned};
        end
        sum_d.sign  = (eff_sub && raw == '0) ? 1'b0 : big_sign;   // Exact cancel gives +0
        sum_d.exp   = big_exp;
        sum_d.carry = raw[WORK_BITS];
        sum_d.sig   = raw[WORK_BITS-1:0];
    end

    // Output register that loads only on a request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_valid <= 1'b0;
            sum       <= '0;
        end else begin
            sum_valid <= in_valid;                  // Strobe follows the request by one cycle
            if (in_valid) begin
                sum <= sum_d;
            end
        end
    end

endmodule

//--- verilog/find_first_1.sv
// Leading-one position finder
`timescale 1ns/100ps

module find_first_1 #(
    parameter int WIDTH = 27                        // Search width, at most 32 bits
) (
    input  logic [WIDTH-1:0] vec,                   // Vector to search
    output logic [4:0]       pos                    // Index of the highest set bit
);

    logic found;                                    // A set bit was seen while scanning down

    // Scan from the top down and latch on the first one seen
    always_comb begin
        pos   = '0;                                 // Zero vector reports index zero
        found = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (vec[i] && !found) begin
                pos   = 5'(i);                      // Highest set bit wins
                found = 1'b1;                       // Lower bits are ignored from here on
            end
        end
    end

    // The caller screens out an all-zero vector, so pos is only
    // meaningful when at least one bit is set. Bit 0 and an empty
    // vector both give zero here

endmodule

//--- verilog/fp_pkg.sv
// Floating-point adder shared types
package fp_pkg;

    // Binary32 field widths
    localparam int EXP_BITS = 8;                    // Biased exponent field
    localparam int SIG_BITS = 23;                   // Stored fraction field, hidden bit excluded
    localparam int EXP_BIAS = 127;                  // Exponent bias, 2*bias+1 is the all-ones code

    // Working significand is hidden bit, fraction, then guard, round and sticky
    localparam int WORK_BITS = SIG_BITS + 4;

    // External operand and result word, bit order matches the IEEE encoding
    typedef struct packed {
        logic                sign;                  // Sign bit, set for negative
        logic [EXP_BITS-1:0] exp;                   // Biased exponent
        logic [SIG_BITS-1:0] frac;                  // Fraction without hidden bit
    } fp_word_t;

    // Stage 1 output, raw significand sum before normalization
    typedef struct packed {
        logic                 sign;                 // Sign of the larger operand
        logic [EXP_BITS-1:0]  exp;                  // Larger exponent, denormals read as 1
        logic                 carry;                // Carry out of the significand adder
        logic [WORK_BITS-1:0] sig;                  // Sum with guard, round and sticky
    } sum_t;

    // Stage 2 output, significand with the leading one at the top
    typedef struct packed {
        logic                 sign;                 // Result sign
        logic [EXP_BITS-1:0]  exp;                  // Adjusted exponent, zero for a denormal
        logic [WORK_BITS-1:0] sig;                  // Normalized significand with GRS bits
    } norm_t;

    // Bit positions inside the working significand
    localparam int HID_POS   = WORK_BITS - 1;       // Hidden bit
    localparam int LSB_POS   = 3;                   // Lowest kept fraction bit
    localparam int GUARD_POS = 2;                   // First bit below the fraction
    localparam int ROUND_POS = 1;                   // Second bit below the fraction
    localparam int STKY_POS  = 0;                   // OR of everything further down

    // All-ones exponent marks infinity
    localparam int EXP_MAX = 2 * EXP_BIAS + 1;

endpackage
